//--- llc_plru.f
+incdir+tb
logic/llc_plru_pkg.sv
logic/plru_tree_ram.sv
logic/plru_tree_update.sv
logic/plru_victim_select.sv
logic/plru_ctrl.sv
logic/llc_plru.sv
tb/tb_llc_plru.sv

//--- Makefile
# Verilator build and run of the pseudo-LRU testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tb_llc_plru
FILELIST  := llc_plru.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := === FAIL ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -qF -- "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/plru_ref_model.svh
// Reference model of the tree pseudo-LRU state for every set
// Expected victim walk and point-away update in heap order

`ifndef PLRU_REF_MODEL_SVH
`define PLRU_REF_MODEL_SVH

// Tree bits per set as the DUT should hold them
tree_t model_tree [LINES];

function automatic logic all_avoided(input way_mask_t avoid, input int first, input int count);
    logic all_set;

    all_set = 1'b1;
    for (int w = first; w < first + count; w++) begin
        all_set = all_set & avoid[w];
    end
    return all_set;
endfunction

// Node n has children 2n+1 (lower ways) and 2n+2 (upper ways)
function automatic way_mask_t expect_victim(
    input tree_t     tree,
    input way_mask_t valid,
    input way_mask_t lock
);
    way_mask_t avoid;
    way_mask_t result;
    int        node;
    int        first;
    int        size;

    result = '0;
    if (lock != '1) begin
        // Free ways win, so only locked ways are avoided in a full set
        avoid = ((valid | lock) == '1) ? lock : (valid | lock);
        node  = 0;
        first = 0;
        size  = WAYS;
        while (size > 1) begin
            size = size / 2;
            if (all_avoided(avoid, first, size)) begin
                first = first + size;
                node  = 2 * node + 2;
            end else if (all_avoided(avoid, first + size, size)) begin
                node = 2 * node + 1;
            end else if (tree[node]) begin
                first = first + size;
                node  = 2 * node + 2;
            end else begin
                node = 2 * node + 1;
            end
        end
        result[first] = 1'b1;
    end
    return result;
endfunction

// Every node on the way's path points to the other half
function automatic tree_t point_away(input tree_t tree, input way_mask_t way);
    tree_t result;
    int    w;
    int    node;
    int    first;
    int    size;

    result = tree;
    if (way != '0) begin
        w = 0;
        for (int i = 0; i < WAYS; i++) begin
            if (way[i]) begin
                w = i;
            end
        end
        node  = 0;
        first = 0;
        size  = WAYS;
        while (size > 1) begin
            size = size / 2;
            if (w < first + size) begin
                result[node] = 1'b1;
                node         = 2 * node + 1;
            end else begin
                result[node] = 1'b0;
                first        = first + size;
                node         = 2 * node + 2;
            end
        end
    end
    return result;
endfunction

`endif

//--- tb/tb_llc_plru.sv
// Testbench for the tree pseudo-LRU replacement unit
// Directed and random hit and evict requests checked against a reference model
// Also holds the protocol assertions, the run timeout and the final report

`timescale 1ns/1ns

module tb_llc_plru;

    localparam int WAYS       = 8;
    localparam int LINES      = 16;
    localparam int IDX_W      = $clog2(LINES);
    // Directed requests outside the random loops
    localparam int N_FIXED    = 16;
    localparam int N_FREE     = 24;
    localparam int N_LOCK     = 20;
    localparam int N_DIRTY    = 16;
    localparam int N_MIX      = 200;
    localparam int TOTAL_REQ  = N_FIXED + N_FREE + N_LOCK + N_DIRTY + N_MIX;
    localparam int MAX_CYCLES = 8 * TOTAL_REQ + 100;
    localparam logic [31:0] SEED = 32'h7e29;
    localparam int HIT_SEQ [5] = '{0, 3, 5, 6, 1};

    typedef logic [WAYS-1:0]  way_mask_t;
    typedef logic [WAYS-2:0]  tree_t;
    typedef logic [IDX_W-1:0] set_t;

    `include "plru_ref_model.svh"

    logic      clk_i;
    logic      rst_i;
    set_t      set_index_i;
    logic      hit_i;
    way_mask_t hit_way_i;
    logic      evict_i;
    way_mask_t tag_valid_i;
    way_mask_t tag_dirty_i;
    way_mask_t spm_lock_i;
    logic      ready_o;
    logic      hit_done_o;
    logic      victim_valid_o;
    way_mask_t victim_way_o;
    logic      evict_o;

    int error_count     = 0;
    int errors_at_start = 0;
    int tests_passed    = 0;
    int tests_failed    = 0;
    int cycle_count     = 0;

    llc_plru #(
        .NUM_WAYS       ( WAYS           ),
        .NUM_LINES      ( LINES          )
    ) u_llc_plru (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .set_index_i    ( set_index_i    ),
        .hit_i          ( hit_i          ),
        .hit_way_i      ( hit_way_i      ),
        .evict_i        ( evict_i        ),
        .tag_valid_i    ( tag_valid_i    ),
        .tag_dirty_i    ( tag_dirty_i    ),
        .spm_lock_i     ( spm_lock_i     ),
        .ready_o        ( ready_o        ),
        .hit_done_o     ( hit_done_o     ),
        .victim_valid_o ( victim_valid_o ),
        .victim_way_o   ( victim_way_o   ),
        .evict_o        ( evict_o        )
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Result pulses only while the unit is busy
    busy_during_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        (hit_done_o || victim_valid_o) |-> !ready_o)
        else begin
            $display("At %0t ns a result pulse came while ready_o was high", $time);
            error_count++;
        end

    // Victim and write-back flag only with a victim result
    victim_with_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        !victim_valid_o |-> (victim_way_o == '0 && !evict_o))
        else begin
            $display("At %0t ns victim_way_o or evict_o was set without victim_valid_o", $time);
            error_count++;
        end

    single_cycle_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        (hit_done_o || victim_valid_o) |-> !$past(hit_done_o || victim_valid_o))
        else begin
            $display("At %0t ns a result pulse lasted longer than one cycle", $time);
            error_count++;
        end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t ns: %s expected %0h got %0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    function automatic way_mask_t one_hot(input int k);
        way_mask_t result;

        result    = '0;
        result[k] = 1'b1;
        return result;
    endfunction

    // One request: drive, wait for the result pulse, compare with the model
    task automatic run_request(
        input  logic      is_evict,
        input  logic      with_hit,
        input  set_t      idx,
        input  way_mask_t hit_way,
        input  way_mask_t valid,
        input  way_mask_t dirty,
        input  way_mask_t lock,
        input  int        gap,
        output way_mask_t got_way
    );
        tree_t     tree_before;
        way_mask_t exp_way;
        logic      exp_dirty;
        int        latency;

        repeat (gap) @(posedge clk_i);
        @(posedge clk_i);
        set_index_i <= idx;
        hit_i       <= !is_evict || with_hit;
        evict_i     <= is_evict;
        hit_way_i   <= hit_way;
        tag_valid_i <= valid;
        tag_dirty_i <= dirty;
        spm_lock_i  <= lock;
        @(negedge clk_i);
        check_value("ready_o before accept", 32'(ready_o), 32'd1);
        check_value("hit_done_o before accept", 32'(hit_done_o), 32'd0);
        check_value("victim_valid_o before accept", 32'(victim_valid_o), 32'd0);
        @(posedge clk_i);
        hit_i   <= 1'b0;
        evict_i <= 1'b0;

        tree_before = model_tree[idx];
        exp_way     = '0;
        exp_dirty   = 1'b0;
        if (is_evict) begin
            exp_way         = expect_victim(tree_before, valid, lock);
            exp_dirty       = |(dirty & exp_way);
            model_tree[idx] = point_away(tree_before, exp_way);
        end else begin
            model_tree[idx] = point_away(tree_before, hit_way);
        end

        latency = 0;
        do begin
            @(negedge clk_i);
            latency++;
            check_value("ready_o while busy", 32'(ready_o), 32'd0);
        end while (!hit_done_o && !victim_valid_o && latency < 8);

        check_value("result latency in cycles", 32'(latency), 32'd2);
        check_value("hit_done_o", 32'(hit_done_o), 32'(!is_evict));
        check_value("victim_valid_o", 32'(victim_valid_o), 32'(is_evict));
        check_value("victim_way_o", 32'(victim_way_o), 32'(exp_way));
        check_value("evict_o", 32'(evict_o), 32'(exp_dirty));
        got_way = victim_way_o;
    endtask

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the requests did not finish", cycle_count);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        set_t        idx;
        way_mask_t   got;
        way_mask_t   valid;
        way_mask_t   lock;
        way_mask_t   dirty;
        int          free_way;
        logic        kind;

        void'($urandom(SEED));
        rst_i       = 1'b1;
        set_index_i = '0;
        hit_i       = 1'b0;
        hit_way_i   = '0;
        evict_i     = 1'b0;
        tag_valid_i = '0;
        tag_dirty_i = '0;
        spm_lock_i  = '0;
        for (int s = 0; s < LINES; s++) begin
            model_tree[s] = '0;
        end

        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("ready_o after reset", 32'(ready_o), 32'd1);
        check_value("hit_done_o after reset", 32'(hit_done_o), 32'd0);
        check_value("victim_valid_o after reset", 32'(victim_valid_o), 32'd0);
        check_value("victim_way_o after reset", 32'(victim_way_o), 32'd0);
        check_value("evict_o after reset", 32'(evict_o), 32'd0);
        end_test("reset_state");

        // Fresh tree bits point at way 0
        run_request(1'b1, 1'b0, set_t'(5), '0, '1, '0, '0, 0, got);
        check_value("victim_way_o on fresh set", 32'(got), 32'd1);
        for (int i = 0; i < 5; i++) begin
            run_request(1'b0, 1'b0, set_t'(2), one_hot(HIT_SEQ[i]), '1, '0, '0, 0, got);
        end
        run_request(1'b1, 1'b0, set_t'(2), '0, '1, way_mask_t'($urandom), '0, 1, got);
        run_request(1'b0, 1'b0, set_t'(2), one_hot(7), '1, '0, '0, 0, got);
        run_request(1'b0, 1'b0, set_t'(2), one_hot(2), '1, '0, '0, 2, got);
        run_request(1'b0, 1'b0, set_t'(2), one_hot(4), '1, '0, '0, 0, got);
        run_request(1'b1, 1'b0, set_t'(2), '0, '1, way_mask_t'($urandom), '0, 0, got);
        end_test("hit_update");

        for (int i = 0; i < N_FREE; i++) begin
            free_way = int'($urandom % WAYS);
            valid    = way_mask_t'($urandom) & ~one_hot(free_way);
            lock     = way_mask_t'($urandom & $urandom) & ~one_hot(free_way);
            dirty    = way_mask_t'($urandom);
            run_request(1'b1, 1'b0, set_t'($urandom), '0, valid, dirty, lock,
                        int'($urandom % 2), got);
            check_value("victim_way_o in free ways", 32'(|(got & ~valid & ~lock)), 32'd1);
        end
        end_test("free_way");

        for (int i = 0; i < N_LOCK; i++) begin
            lock = way_mask_t'($urandom);
            if (lock == '1) begin
                lock = lock & ~one_hot(int'($urandom % WAYS));
            end
            run_request(1'b1, 1'b0, set_t'($urandom), '0, '1, way_mask_t'($urandom),
                        lock, 0, got);
            check_value("victim_way_o outside locked ways", 32'(got & lock), 32'd0);
        end
        run_request(1'b0, 1'b0, set_t'(7), one_hot(2), '1, '0, '0, 0, got);
        run_request(1'b0, 1'b0, set_t'(7), one_hot(5), '1, '0, '0, 0, got);
        // Fully locked set, then an open evict shows the bits were kept
        run_request(1'b1, 1'b0, set_t'(7), '0, '1, '1, '1, 0, got);
        check_value("victim_way_o with all ways locked", 32'(got), 32'd0);
        run_request(1'b1, 1'b0, set_t'(7), '0, '1, '0, '0, 0, got);
        end_test("spm_lock");

        for (int i = 0; i < N_DIRTY; i++) begin
            dirty = way_mask_t'($urandom);
            run_request(1'b1, 1'b0, set_t'($urandom), '0, '1, dirty, '0, 0, got);
        end
        run_request(1'b1, 1'b0, set_t'(11), '0, '1, '1, '1, 0, got);
        end_test("dirty_flag");

        idx = '0;
        for (int i = 0; i < N_MIX; i++) begin
            // Half the requests revisit the previous set
            if (($urandom % 2) == 0) begin
                idx = set_t'($urandom);
            end
            kind  = ($urandom % 3) == 0;
            valid = (($urandom % 4) == 0) ? way_mask_t'($urandom) : '1;
            lock  = way_mask_t'($urandom & $urandom & $urandom);
            dirty = way_mask_t'($urandom);
            run_request(kind, ($urandom % 4) == 0, idx, one_hot(int'($urandom % WAYS)),
                        valid, dirty, lock, int'($urandom % 3), got);
        end
        @(negedge clk_i);
        check_value("ready_o after last request", 32'(ready_o), 32'd1);
        check_value("hit_done_o after last request", 32'(hit_done_o), 32'd0);
        check_value("victim_valid_o after last request", 32'(victim_valid_o), 32'd0);
        end_test("random_mix");

        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- logic/llc_plru.sv
// Top level of the tree pseudo-LRU replacement unit
// Connects the controller to the per-set tree storage

`timescale 1ns/1ns

module llc_plru import llc_plru_pkg::*; #(
    parameter int unsigned NUM_WAYS  = NUM_WAYS_DEF,
    parameter int unsigned NUM_LINES = NUM_LINES_DEF
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [$clog2(NUM_LINES)-1:0] set_index_i,
    input  logic                         hit_i,
    input  logic [NUM_WAYS-1:0]          hit_way_i,
    input  logic                         evict_i,
    input  logic [NUM_WAYS-1:0]          tag_valid_i,
    input  logic [NUM_WAYS-1:0]          tag_dirty_i,
    input  logic [NUM_WAYS-1:0]          spm_lock_i,
    output logic                         ready_o,
    output logic                         hit_done_o,
    output logic                         victim_valid_o,
    output logic [NUM_WAYS-1:0]          victim_way_o,
    output logic                         evict_o
);

    typedef logic [NUM_WAYS-2:0]          tree_bits_t;
    typedef logic [$clog2(NUM_LINES)-1:0] set_index_t;

    logic       ram_req;
    logic       ram_we;
    set_index_t ram_index;
    tree_bits_t ram_wdata;
    tree_bits_t ram_rdata;

    plru_ctrl #(
        .NUM_WAYS       ( NUM_WAYS       ),
        .NUM_LINES      ( NUM_LINES      )
    ) u_plru_ctrl (
        .clk_i          ( clk_i          ),
        .rst_i          ( rst_i          ),
        .set_index_i    ( set_index_i    ),
        .hit_i          ( hit_i          ),
        .hit_way_i      ( hit_way_i      ),
        .evict_i        ( evict_i        ),
        .tag_valid_i    ( tag_valid_i    ),
        .tag_dirty_i    ( tag_dirty_i    ),
        .spm_lock_i     ( spm_lock_i     ),
        .ram_rdata_i    ( ram_rdata      ),
        .ram_req_o      ( ram_req        ),
        .ram_we_o       ( ram_we         ),
        .ram_index_o    ( ram_index      ),
        .ram_wdata_o    ( ram_wdata      ),
        .ready_o        ( ready_o        ),
        .hit_done_o     ( hit_done_o     ),
        .victim_valid_o ( victim_valid_o ),
        .victim_way_o   ( victim_way_o   ),
        .evict_o        ( evict_o        )
    );

    plru_tree_ram #(
        .NUM_WAYS  ( NUM_WAYS  ),
        .NUM_LINES ( NUM_LINES )
    ) u_plru_tree_ram (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .req_i     ( ram_req   ),
        .we_i      ( ram_we    ),
        .index_i   ( ram_index ),
        .wdata_i   ( ram_wdata ),
        .rdata_o   ( ram_rdata )
    );

endmodule

//--- logic/plru_ctrl.sv
// Request sequencing for the pseudo-LRU unit
// Reads the tree bits, writes back the update and pulses the results

`timescale 1ns/1ns

module plru_ctrl import llc_plru_pkg::*; #(
    parameter int unsigned NUM_WAYS  = NUM_WAYS_DEF,
    parameter int unsigned NUM_LINES = NUM_LINES_DEF
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [$clog2(NUM_LINES)-1:0] set_index_i,
    input  logic                         hit_i,
    input  logic [NUM_WAYS-1:0]          hit_way_i,
    input  logic                         evict_i,
    input  logic [NUM_WAYS-1:0]          tag_valid_i,
    input  logic [NUM_WAYS-1:0]          tag_dirty_i,
    input  logic [NUM_WAYS-1:0]          spm_lock_i,
    input  logic [NUM_WAYS-2:0]          ram_rdata_i,
    output logic                         ram_req_o,
    output logic                         ram_we_o,
    output logic [$clog2(NUM_LINES)-1:0] ram_index_o,
    output logic [NUM_WAYS-2:0]          ram_wdata_o,
    output logic                         ready_o,
    output logic                         hit_done_o,
    output logic                         victim_valid_o,
    output logic [NUM_WAYS-1:0]          victim_way_o,
    output logic                         evict_o
);

    typedef logic [NUM_WAYS-1:0]          way_mask_t;
    typedef logic [NUM_WAYS-2:0]          tree_bits_t;
    typedef logic [$clog2(NUM_LINES)-1:0] set_index_t;

    plru_state_e state_q;
    set_index_t  index_q;
    logic        is_evict_q;
    way_mask_t   hit_way_q;

    logic        hit_done_q;
    logic        victim_valid_q;
    way_mask_t   victim_way_q;
    logic        evict_q;

    logic        req_take;
    logic        write_en;
    way_mask_t   sel_way;
    logic        sel_found;
    way_mask_t   upd_way;
    tree_bits_t  upd_tree;

    plru_victim_select #(
        .NUM_WAYS     ( NUM_WAYS    )
    ) u_victim_select (
        .tree_i       ( ram_rdata_i ),
        .tag_valid_i  ( tag_valid_i ),
        .spm_lock_i   ( spm_lock_i  ),
        .victim_way_o ( sel_way     ),
        .found_o      ( sel_found   )
    );

    plru_tree_update #(
        .NUM_WAYS ( NUM_WAYS    )
    ) u_tree_update (
        .tree_i   ( ram_rdata_i ),
        .way_i    ( upd_way     ),
        .tree_o   ( upd_tree    )
    );

    // Evict wins over a simultaneous hit
    assign req_take = (state_q == IDLE) && (hit_i || evict_i);
    assign upd_way  = is_evict_q ? sel_way : hit_way_q;
    // Fully locked set keeps its bits
    assign write_en = !is_evict_q || sel_found;

    always_comb begin
        ram_req_o   = 1'b0;
        ram_we_o    = 1'b0;
        ram_index_o = set_index_i;
        ram_wdata_o = upd_tree;
        if (req_take) begin
            ram_req_o = 1'b1;
        end else if (state_q == READ) begin
            ram_req_o   = write_en;
            ram_we_o    = write_en;
            ram_index_o = index_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q        <= IDLE;
            hit_done_q     <= 1'b0;
            victim_valid_q <= 1'b0;
            victim_way_q   <= '0;
            evict_q        <= 1'b0;
        end else begin
            // Result registers are single-cycle pulses
            hit_done_q     <= 1'b0;
            victim_valid_q <= 1'b0;
            victim_way_q   <= '0;
            evict_q        <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (req_take) begin
                        state_q <= READ;
                    end
                end
                READ: begin
                    state_q <= APPLY;
                    if (is_evict_q) begin
                        victim_valid_q <= 1'b1;
                        victim_way_q   <= sel_way;
                        evict_q        <= |(tag_dirty_i & sel_way);
                    end else begin
                        hit_done_q <= 1'b1;
                    end
                end
                APPLY: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Request details held for the read cycle
    always_ff @(posedge clk_i) begin
        if (req_take) begin
            index_q    <= set_index_i;
            is_evict_q <= evict_i;
            hit_way_q  <= hit_way_i;
        end
    end

    assign ready_o        = (state_q == IDLE);
    assign hit_done_o     = hit_done_q;
    assign victim_valid_o = victim_valid_q;
    assign victim_way_o   = victim_way_q;
    assign evict_o        = evict_q;

endmodule

//--- logic/plru_victim_select.sv
// Combinational tree walk that picks the victim way of a set
// Free ways are preferred and scratchpad-locked ways are skipped

`timescale 1ns/1ns

module plru_victim_select import llc_plru_pkg::*; #(
    parameter int unsigned NUM_WAYS = NUM_WAYS_DEF
) (
    input  logic [NUM_WAYS-2:0] tree_i,
    input  logic [NUM_WAYS-1:0] tag_valid_i,
    input  logic [NUM_WAYS-1:0] spm_lock_i,
    output logic [NUM_WAYS-1:0] victim_way_o,
    output logic                found_o
);

    localparam int unsigned LEVELS = $clog2(NUM_WAYS);

    typedef logic [NUM_WAYS-1:0] way_mask_t;

    way_mask_t occupied;
    way_mask_t avoid;
    way_mask_t pick;

    assign occupied = tag_valid_i | spm_lock_i;

    // With a free way present, every occupied way is avoided
    // Otherwise only the locked ways are
    assign avoid = (&occupied) ? spm_lock_i : occupied;

    assign found_o = ~(&spm_lock_i);

    always_comb begin
        int   node;
        int   lo;
        int   span;
        logic left_all;
        logic right_all;
        logic go_right;

        node = 0;
        lo   = 0;
        for (int lvl = 0; lvl < LEVELS; lvl++) begin
            span      = NUM_WAYS >> lvl;
            left_all  = 1'b1;
            right_all = 1'b1;
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (w >= lo && w < lo + span / 2) begin
                    left_all = left_all & avoid[w];
                end else if (w >= lo + span / 2 && w < lo + span) begin
                    right_all = right_all & avoid[w];
                end
            end

            // Forced direction first, then the stored bit
            if (left_all) begin
                go_right = 1'b1;
            end else if (right_all) begin
                go_right = 1'b0;
            end else begin
                go_right = tree_i[node];
            end

            if (go_right) begin
                lo = lo + span / 2;
            end
            node = 2 * node + 1 + int'(go_right);
        end

        // Walk ends on a single way
        pick     = '0;
        pick[lo] = 1'b1;
    end

    assign victim_way_o = found_o ? pick : '0;

endmodule

//--- logic/plru_tree_update.sv
// Combinational tree-bit rewrite for a hit or a chosen victim
// Every node on the way's path is turned to point away from that way

`timescale 1ns/1ns

module plru_tree_update import llc_plru_pkg::*; #(
    parameter int unsigned NUM_WAYS = NUM_WAYS_DEF
) (
    input  logic [NUM_WAYS-2:0] tree_i,
    input  logic [NUM_WAYS-1:0] way_i,
    output logic [NUM_WAYS-2:0] tree_o
);

    localparam int unsigned LEVELS = $clog2(NUM_WAYS);

    typedef logic [NUM_WAYS-2:0] tree_bits_t;

    tree_bits_t tree_next;

    // Heap order: level lvl holds nodes 2**lvl-1 upwards, each covering span ways
    always_comb begin
        int   node;
        int   span;
        int   lo;
        logic in_left;
        logic in_right;

        tree_next = tree_i;
        for (int lvl = 0; lvl < LEVELS; lvl++) begin
            span = NUM_WAYS >> lvl;
            for (int k = 0; k < (1 << lvl); k++) begin
                node     = (1 << lvl) - 1 + k;
                lo       = k * span;
                in_left  = 1'b0;
                in_right = 1'b0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    if (w >= lo && w < lo + span / 2) begin
                        in_left = in_left | way_i[w];
                    end else if (w >= lo + span / 2 && w < lo + span) begin
                        in_right = in_right | way_i[w];
                    end
                end
                // Bit 1 steers the next victim into the upper half
                if (in_left) begin
                    tree_next[node] = 1'b1;
                end else if (in_right) begin
                    tree_next[node] = 1'b0;
                end
            end
        end
    end

    assign tree_o = tree_next;

endmodule

//--- logic/plru_tree_ram.sv
// Per-set storage of the pseudo-LRU tree bits
// Register array with synchronous write and a registered one-cycle read

`timescale 1ns/1ns

module plru_tree_ram import llc_plru_pkg::*; #(
    parameter int unsigned NUM_WAYS  = NUM_WAYS_DEF,
    parameter int unsigned NUM_LINES = NUM_LINES_DEF
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [$clog2(NUM_LINES)-1:0] index_i,
    input  logic [NUM_WAYS-2:0]          wdata_i,
    output logic [NUM_WAYS-2:0]          rdata_o
);

    typedef logic [NUM_WAYS-2:0] tree_bits_t;

    tree_bits_t mem_q [NUM_LINES];

    // All sets start from the all-zero tree, so way 0 is the first victim
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                mem_q[i] <= '0;
            end
        end else if (req_i && we_i) begin
            mem_q[index_i] <= wdata_i;
        end
    end

    // Read data holds until the next read request
    always_ff @(posedge clk_i) begin
        if (req_i && !we_i) begin
            rdata_o <= mem_q[index_i];
        end
    end

endmodule

//--- logic/llc_plru_pkg.sv
// Shared definitions for the tree pseudo-LRU replacement unit
// Default cache geometry and the controller state encoding

package llc_plru_pkg;

    // Default associativity, must be a power of two between 2 and 64
    localparam int unsigned NUM_WAYS_DEF = 8;

    // Default number of sets
    localparam int unsigned NUM_LINES_DEF = 16;

    // Controller sequence
    // IDLE   waiting for a request, storage read issued on accept
    // READ   tree bits valid, update written back
    // APPLY  result pulse on the outputs
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        APPLY = 2'd2
    } plru_state_e;

endpackage
